// File: testbench/rdma_hndshk_patterns.txt
# qpid wqe_count laddr payload_len opcode r_key sq_addr sq_pidb_addr early_cq (all hex)
# early_cq is sent only when below the expected index; ffffffff means none
0011 3 0000000010000000 40 4 a1a1 0000000200000000 f000 1
00a2 1 00000001fffff000 1000 8 b2b2 0000000200001000 f004 3
0133 5 0000000000002000 200 4 c3c3 00000003ffffff80 f008 6
0044 0 0000000000000000 10 2 d4d4 0000000000004000 f00c ffffffff
01f5 2 ffffffff00000000 80000000 6 e5e5 0000000000005000 f010 a
0066 4 0000000000123400 3 4 f6f6 0000000000006000 f014 d
0077 1 0000000000000040 40 0 0707 0000000000007000 f018 f
00c8 6 0000000100000000 800 8 1818 0000000000008000 f01c 14

// File: rdma_hndshk.f
src/rdma_hndshk_pkg.sv
src/cmd_regs.sv
src/wqe_writer.sv
src/cq_waiter.sv
src/hndshk_sequencer.sv
src/rdma_hndshk_top.sv
testbench/rdma_hndshk_assertions.sv
testbench/tb_rdma_hndshk.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the RDMA handshake testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f rdma_hndshk.f \
  --top-module tb_rdma_hndshk -o tb_rdma_hndshk
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

output="$(./obj_dir/tb_rdma_hndshk 2>&1)"
status=$?
echo "$output"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "No errors" <<< "$output"; then
  exit 0
fi
exit 1

// File: testbench/tb_rdma_hndshk.sv
// Testbench for the RDMA send-queue handshake engine.
// Replays commands from the pattern file, answers with CQ doorbells after
// pseudo-random gaps and checks WQEs, doorbell and status against the spec.
`timescale 1ns/1ps

module tb_rdma_hndshk;

  localparam int WAIT_LIMIT = 64;

  logic                      axis_aclk;
  logic                      axis_rstn;
  logic                      cfg_valid;
  rdma_hndshk_pkg::cfg_idx_t cfg_idx;
  rdma_hndshk_pkg::word_t    cfg_data;
  logic                      mem_wr_valid;
  rdma_hndshk_pkg::addr_t    mem_wr_addr;
  rdma_hndshk_pkg::wqe_t     mem_wr_data;
  logic                      sq_db_valid;
  rdma_hndshk_pkg::qpid_t    sq_db_qpid;
  rdma_hndshk_pkg::pidx_t    sq_db_pidx;
  rdma_hndshk_pkg::word_t    sq_db_addr;
  logic                      cq_db_valid;
  rdma_hndshk_pkg::pidx_t    cq_db_cnt;
  rdma_hndshk_pkg::timer_t   global_hw_timer;
  logic                      status_valid;
  rdma_hndshk_pkg::status_t  status_word;
  logic                      idle;

  logic [15:0]               lfsr;
  rdma_hndshk_pkg::word_t    exp_wrid;
  rdma_hndshk_pkg::pidx_t    exp_pidx;

  rdma_hndshk_top UUT (.*);

  bind rdma_hndshk_top rdma_hndshk_assertions u_checks (
    .axis_aclk    (axis_aclk),
    .axis_rstn    (axis_rstn),
    .sq_db_valid  (sq_db_valid),
    .mem_wr_valid (mem_wr_valid),
    .status_valid (status_valid),
    .cq_db_valid  (cq_db_valid),
    .cq_db_cnt    (cq_db_cnt),
    .last_cq_cnt  (u_cq_waiter.last_cq_cnt)
  );

  always #5 axis_aclk = ~axis_aclk;

  always @(negedge axis_aclk) global_hw_timer <= global_hw_timer + 64'd1;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [255:0] got,
                             input logic [255:0] exp);
    assert (got === exp) else begin
      stop_on_error($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // Outputs settle after the rising edge, so sample just past the falling edge.
  task automatic tick();
    @(negedge axis_aclk);
    #1;
  endtask

  task automatic check_quiet();
    check_value("mem_wr_valid", 256'(mem_wr_valid), 256'd0);
    check_value("sq_db_valid", 256'(sq_db_valid), 256'd0);
    check_value("status_valid", 256'(status_valid), 256'd0);
  endtask

  // Galois LFSR, one step per bit taken.
  function automatic int lfsr_bits(input int n);
    logic b;
    int val;
    val = 0;
    for (int k = 0; k < n; k++) begin
      b = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) lfsr = lfsr ^ 16'hB400;
      val = (val << 1) | int'(b);
    end
    return val;
  endfunction

  task automatic write_reg(input rdma_hndshk_pkg::cfg_idx_t idx, input logic [31:0] data);
    cfg_valid = 1'b1;
    cfg_idx   = idx;
    cfg_data  = data;
    tick();
    cfg_valid = 1'b0;
    cfg_idx   = '0;
    cfg_data  = '0;
    check_quiet();
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (!idle && n < WAIT_LIMIT) begin
      tick();
      n++;
    end
    assert (idle) else stop_on_error("Timed out waiting for the engine to become idle");
  endtask

  function automatic rdma_hndshk_pkg::wqe_t expected_wqe(input logic [31:0] wrid,
      input logic [31:0] opc, input logic [31:0] len, input logic [31:0] rkey,
      input logic [63:0] la, input logic [15:0] qp);
    rdma_hndshk_pkg::wqe_t e;
    e[31:0]    = wrid;
    e[63:32]   = opc;
    e[95:64]   = len;
    e[127:96]  = rkey;
    e[191:128] = la;
    e[255:192] = 64'(qp);
    return e;
  endfunction

  task automatic run_command(input logic [15:0] qp, input logic [31:0] cnt,
      input logic [63:0] la, input logic [31:0] len, input logic [31:0] opc,
      input logic [31:0] rkey, input logic [63:0] sqa, input logic [31:0] dba,
      input logic [31:0] early);
    int gap;
    logic [63:0] t_db;
    logic [63:0] t_cq;
    logic [63:0] lat;
    wait_idle();
    write_reg(rdma_hndshk_pkg::REG_QPID, 32'(qp));
    write_reg(rdma_hndshk_pkg::REG_WQE_COUNT, cnt);
    write_reg(rdma_hndshk_pkg::REG_LADDR_LSB, la[31:0]);
    write_reg(rdma_hndshk_pkg::REG_LADDR_MSB, la[63:32]);
    write_reg(rdma_hndshk_pkg::REG_PAYLOAD_LEN, len);
    write_reg(rdma_hndshk_pkg::REG_OPCODE, opc);
    write_reg(rdma_hndshk_pkg::REG_R_KEY, rkey);
    write_reg(rdma_hndshk_pkg::REG_SQ_ADDR_LSB, sqa[31:0]);
    write_reg(rdma_hndshk_pkg::REG_SQ_ADDR_MSB, sqa[63:32]);
    write_reg(rdma_hndshk_pkg::REG_SQ_PIDB_ADDR, dba);
    write_reg(rdma_hndshk_pkg::REG_GO, 32'd1);
    check_value("idle", 256'(idle), 256'd0);
    exp_pidx = exp_pidx + cnt;
    tick();
    for (int i = 0; i < int'(cnt); i++) begin
      check_value("mem_wr_valid", 256'(mem_wr_valid), 256'd1);
      check_value("sq_db_valid", 256'(sq_db_valid), 256'd0);
      check_value("mem_wr_addr", 256'(mem_wr_addr), 256'(sqa + 64'(i) * 64'd64));
      check_value("mem_wr_data", mem_wr_data,
                  expected_wqe(exp_wrid, opc, len, rkey, la + 64'(i) * 64'(len), qp));
      exp_wrid = exp_wrid + 32'd1;
      // A second go while the batch is running must be ignored.
      cfg_valid = (i == 0) && (cnt > 32'd1);
      cfg_idx   = rdma_hndshk_pkg::REG_GO;
      tick();
      cfg_valid = 1'b0;
    end
    check_value("sq_db_valid", 256'(sq_db_valid), 256'd1);
    check_value("mem_wr_valid", 256'(mem_wr_valid), 256'd0);
    check_value("sq_db_qpid", 256'(sq_db_qpid), 256'(qp));
    check_value("sq_db_pidx", 256'(sq_db_pidx), 256'(exp_pidx));
    check_value("sq_db_addr", 256'(sq_db_addr), 256'(dba));
    t_db = global_hw_timer;
    if (early < exp_pidx) begin
      gap = lfsr_bits(3);
      repeat (gap) begin
        tick();
        check_quiet();
      end
      cq_db_valid = 1'b1;
      cq_db_cnt   = early;
      tick();
      cq_db_valid = 1'b0;
      check_quiet();
    end
    gap = lfsr_bits(3);
    repeat (gap) begin
      tick();
      check_quiet();
    end
    cq_db_valid = 1'b1;
    cq_db_cnt   = exp_pidx;
    t_cq        = global_hw_timer;
    tick();
    cq_db_valid = 1'b0;
    lat = t_cq - t_db;
    check_value("status_valid", 256'(status_valid), 256'd1);
    check_value("sq_db_valid", 256'(sq_db_valid), 256'd0);
    check_value("idle", 256'(idle), 256'd0);
    check_value("status_word", 256'(status_word), 256'({qp[7:0], lat[23:0]}));
    tick();
    check_value("status_valid", 256'(status_valid), 256'd0);
    check_value("idle", 256'(idle), 256'd1);
  endtask

  initial begin
    int fd;
    int n;
    int cmds;
    string line;
    logic [63:0] f[9];
    axis_aclk       = 1'b0;
    axis_rstn       = 1'b0;
    cfg_valid       = 1'b0;
    cfg_idx         = '0;
    cfg_data        = '0;
    cq_db_valid     = 1'b0;
    cq_db_cnt       = '0;
    global_hw_timer = '0;
    lfsr            = 16'd39614;
    exp_wrid        = '0;
    exp_pidx        = '0;
    cmds            = 0;
    repeat (5) @(negedge axis_aclk);
    axis_rstn = 1'b1;
    tick();
    check_value("idle", 256'(idle), 256'd1);
    check_quiet();
    fd = $fopen("testbench/rdma_hndshk_patterns.txt", "r");
    assert (fd != 0) else stop_on_error("Could not open the pattern file");
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 0 && line.getc(0) != 8'h23) begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
        if (n > 0) begin
          assert (n == 9) else stop_on_error("Pattern line has missing fields");
          run_command(f[0][15:0], f[1][31:0], f[2], f[3][31:0], f[4][31:0],
                      f[5][31:0], f[6], f[7][31:0], f[8][31:0]);
          cmds++;
        end
      end
    end
    $fclose(fd);
    assert (cmds > 0) else stop_on_error("The pattern file holds no commands");
    if (UUT.u_checks.fail_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: testbench/rdma_hndshk_assertions.sv
// Protocol assertions for the RDMA handshake engine.
// Bound into the design to watch strobe overlap, status pulse width and
// the ordering of CQ doorbell counts.
`timescale 1ns/1ps

module rdma_hndshk_assertions (
  input logic                   axis_aclk,
  input logic                   axis_rstn,
  input logic                   sq_db_valid,
  input logic                   mem_wr_valid,
  input logic                   status_valid,
  input logic                   cq_db_valid,
  input rdma_hndshk_pkg::pidx_t cq_db_cnt,
  input rdma_hndshk_pkg::pidx_t last_cq_cnt
);

  // Number of assertion failures so far.
  int unsigned fail_count = 0;

  // The doorbell is rung only after the last WQE has gone out.
  db_after_wqe: assert property (@(posedge axis_aclk) disable iff (!axis_rstn)
    !(sq_db_valid && mem_wr_valid))
    else begin
      $error("SQ doorbell and memory write strobe are high together");
      fail_count++;
    end

  status_one_cycle: assert property (@(posedge axis_aclk) disable iff (!axis_rstn)
    status_valid |=> !status_valid)
    else begin
      $error("Status strobe lasted more than one cycle");
      fail_count++;
    end

  // CQ counts only move forward.
  cq_cnt_monotonic: assert property (@(posedge axis_aclk) disable iff (!axis_rstn)
    cq_db_valid |-> (cq_db_cnt >= last_cq_cnt))
    else begin
      $error("CQ doorbell count went backwards");
      fail_count++;
    end

endmodule

// File: src/rdma_hndshk_top.sv
// RDMA send-queue handshake engine, top level.
// Register file, WQE writer, CQ waiter and sequencer wired together.
`timescale 1ns/1ps

module rdma_hndshk_top (
  input  logic                      axis_aclk,
  input  logic                      axis_rstn,
  input  logic                      cfg_valid,
  input  rdma_hndshk_pkg::cfg_idx_t cfg_idx,
  input  rdma_hndshk_pkg::word_t    cfg_data,
  output logic                      mem_wr_valid,
  output rdma_hndshk_pkg::addr_t    mem_wr_addr,
  output rdma_hndshk_pkg::wqe_t     mem_wr_data,
  output logic                      sq_db_valid,
  output rdma_hndshk_pkg::qpid_t    sq_db_qpid,
  output rdma_hndshk_pkg::pidx_t    sq_db_pidx,
  output rdma_hndshk_pkg::word_t    sq_db_addr,
  input  logic                      cq_db_valid,
  input  rdma_hndshk_pkg::pidx_t    cq_db_cnt,
  input  rdma_hndshk_pkg::timer_t   global_hw_timer,
  output logic                      status_valid,
  output rdma_hndshk_pkg::status_t  status_word,
  output logic                      idle
);

  rdma_hndshk_pkg::qpid_t qpid;
  rdma_hndshk_pkg::word_t wqe_count;
  rdma_hndshk_pkg::addr_t laddr;
  rdma_hndshk_pkg::word_t payload_len;
  rdma_hndshk_pkg::word_t opcode;
  rdma_hndshk_pkg::word_t r_key;
  rdma_hndshk_pkg::addr_t sq_addr;
  rdma_hndshk_pkg::word_t sq_pidb_addr;
  logic                   go;
  logic                   wqe_start;
  logic                   wqe_done;
  logic                   cq_arm;
  logic                   cq_done;
  rdma_hndshk_pkg::pidx_t expect_pidx;

  cmd_regs u_cmd_regs (
    .axis_aclk    (axis_aclk),
    .axis_rstn    (axis_rstn),
    .cfg_valid    (cfg_valid),
    .cfg_idx      (cfg_idx),
    .cfg_data     (cfg_data),
    .qpid         (qpid),
    .wqe_count    (wqe_count),
    .laddr        (laddr),
    .payload_len  (payload_len),
    .opcode       (opcode),
    .r_key        (r_key),
    .sq_addr      (sq_addr),
    .sq_pidb_addr (sq_pidb_addr),
    .go           (go)
  );

  wqe_writer u_wqe_writer (
    .axis_aclk    (axis_aclk),
    .axis_rstn    (axis_rstn),
    .wqe_start    (wqe_start),
    .wqe_count    (wqe_count),
    .qpid         (qpid),
    .laddr        (laddr),
    .payload_len  (payload_len),
    .opcode       (opcode),
    .r_key        (r_key),
    .sq_addr      (sq_addr),
    .mem_wr_valid (mem_wr_valid),
    .mem_wr_addr  (mem_wr_addr),
    .mem_wr_data  (mem_wr_data),
    .wqe_done     (wqe_done)
  );

  cq_waiter u_cq_waiter (
    .axis_aclk   (axis_aclk),
    .axis_rstn   (axis_rstn),
    .cq_arm      (cq_arm),
    .expect_pidx (expect_pidx),
    .cq_db_valid (cq_db_valid),
    .cq_db_cnt   (cq_db_cnt),
    .cq_done     (cq_done)
  );

  hndshk_sequencer u_hndshk_sequencer (
    .axis_aclk       (axis_aclk),
    .axis_rstn       (axis_rstn),
    .go              (go),
    .qpid            (qpid),
    .wqe_count       (wqe_count),
    .sq_pidb_addr    (sq_pidb_addr),
    .wqe_done        (wqe_done),
    .cq_done         (cq_done),
    .global_hw_timer (global_hw_timer),
    .wqe_start       (wqe_start),
    .cq_arm          (cq_arm),
    .expect_pidx     (expect_pidx),
    .sq_db_valid     (sq_db_valid),
    .sq_db_qpid      (sq_db_qpid),
    .sq_db_pidx      (sq_db_pidx),
    .sq_db_addr      (sq_db_addr),
    .status_valid    (status_valid),
    .status_word     (status_word),
    .idle            (idle)
  );

endmodule

// File: src/hndshk_sequencer.sv
// Handshake sequencer.
// Starts the WQE writer, rings the SQ producer-index doorbell, waits for
// the completion and reports the queue pair with its measured latency.
`timescale 1ns/1ps

module hndshk_sequencer (
  input  logic                     axis_aclk,
  input  logic                     axis_rstn,
  input  logic                     go,
  input  rdma_hndshk_pkg::qpid_t   qpid,
  input  rdma_hndshk_pkg::word_t   wqe_count,
  input  rdma_hndshk_pkg::word_t   sq_pidb_addr,
  input  logic                     wqe_done,
  input  logic                     cq_done,
  input  rdma_hndshk_pkg::timer_t  global_hw_timer,
  output logic                     wqe_start,
  output logic                     cq_arm,
  output rdma_hndshk_pkg::pidx_t   expect_pidx,
  output logic                     sq_db_valid,
  output rdma_hndshk_pkg::qpid_t   sq_db_qpid,
  output rdma_hndshk_pkg::pidx_t   sq_db_pidx,
  output rdma_hndshk_pkg::word_t   sq_db_addr,
  output logic                     status_valid,
  output rdma_hndshk_pkg::status_t status_word,
  output logic                     idle
);

  rdma_hndshk_pkg::seq_state_t state;
  rdma_hndshk_pkg::seq_state_t next_state;
  rdma_hndshk_pkg::pidx_t      pidx_q;
  rdma_hndshk_pkg::timer_t     start_timer;
  rdma_hndshk_pkg::timer_t     start_ref;
  rdma_hndshk_pkg::timer_t     latency;

  // ****************************************
  // State machine
  // ****************************************

  always_comb begin
    next_state = state;
    case (state)
      rdma_hndshk_pkg::IDLE: begin
        if (go) begin
          // A zero-length batch is done at once.
          next_state = wqe_done ? rdma_hndshk_pkg::RING_SQDB : rdma_hndshk_pkg::WRITE_WQE;
        end
      end
      rdma_hndshk_pkg::WRITE_WQE: begin
        if (wqe_done) begin
          next_state = rdma_hndshk_pkg::RING_SQDB;
        end
      end
      rdma_hndshk_pkg::RING_SQDB: begin
        next_state = cq_done ? rdma_hndshk_pkg::REPORT : rdma_hndshk_pkg::WAIT_CQDB;
      end
      rdma_hndshk_pkg::WAIT_CQDB: begin
        if (cq_done) begin
          next_state = rdma_hndshk_pkg::REPORT;
        end
      end
      rdma_hndshk_pkg::REPORT: begin
        next_state = rdma_hndshk_pkg::IDLE;
      end
      default: begin
        next_state = rdma_hndshk_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge axis_aclk) begin
    if (!axis_rstn) begin
      state  <= rdma_hndshk_pkg::IDLE;
      pidx_q <= '0;
    end else begin
      state <= next_state;
      // The producer index accumulates every accepted batch.
      if (wqe_start) begin
        pidx_q <= pidx_q + wqe_count;
      end
    end
  end

  // ****************************************
  // Timing and status
  // ****************************************

  // A completion in the doorbell cycle itself measures zero.
  assign start_ref = (state == rdma_hndshk_pkg::RING_SQDB) ? global_hw_timer : start_timer;
  assign latency   = global_hw_timer - start_ref;

  always_ff @(posedge axis_aclk) begin
    if (state == rdma_hndshk_pkg::RING_SQDB) begin
      start_timer <= global_hw_timer;
    end
    if (cq_done) begin
      status_word <= {qpid[7:0], latency[rdma_hndshk_pkg::LATENCY_BITS-1:0]};
    end
  end

  assign wqe_start    = (state == rdma_hndshk_pkg::IDLE) && go;
  assign idle         = (state == rdma_hndshk_pkg::IDLE) && !go;
  assign sq_db_valid  = (state == rdma_hndshk_pkg::RING_SQDB);
  assign sq_db_qpid   = qpid;
  assign sq_db_pidx   = pidx_q;
  assign sq_db_addr   = sq_pidb_addr;
  assign cq_arm       = (state == rdma_hndshk_pkg::RING_SQDB) ||
                        (state == rdma_hndshk_pkg::WAIT_CQDB);
  assign expect_pidx  = pidx_q;
  assign status_valid = (state == rdma_hndshk_pkg::REPORT);

endmodule

// File: src/cq_waiter.sv
// CQ doorbell waiter.
// While armed, flags the first CQ doorbell whose count has reached the
// expected producer index.
`timescale 1ns/1ps

module cq_waiter (
  input  logic                   axis_aclk,
  input  logic                   axis_rstn,
  input  logic                   cq_arm,
  input  rdma_hndshk_pkg::pidx_t expect_pidx,
  input  logic                   cq_db_valid,
  input  rdma_hndshk_pkg::pidx_t cq_db_cnt,
  output logic                   cq_done
);

  // Most recent CQ count seen on the doorbell port.
  rdma_hndshk_pkg::pidx_t last_cq_cnt;

  always_ff @(posedge axis_aclk) begin
    if (!axis_rstn) begin
      last_cq_cnt <= '0;
    end else if (cq_db_valid) begin
      last_cq_cnt <= cq_db_cnt;
    end
  end

  // Unsigned compare; lower counts are stale and simply dropped.
  assign cq_done = cq_arm && cq_db_valid && (cq_db_cnt >= expect_pidx);

endmodule

// File: src/wqe_writer.sv
// WQE writer.
// Builds one work-queue entry per cycle and writes it to system memory
// at consecutive 64-byte slots of the send queue.
`timescale 1ns/1ps

module wqe_writer (
  input  logic                    axis_aclk,
  input  logic                    axis_rstn,
  input  logic                    wqe_start,
  input  rdma_hndshk_pkg::word_t  wqe_count,
  input  rdma_hndshk_pkg::qpid_t  qpid,
  input  rdma_hndshk_pkg::addr_t  laddr,
  input  rdma_hndshk_pkg::word_t  payload_len,
  input  rdma_hndshk_pkg::word_t  opcode,
  input  rdma_hndshk_pkg::word_t  r_key,
  input  rdma_hndshk_pkg::addr_t  sq_addr,
  output logic                    mem_wr_valid,
  output rdma_hndshk_pkg::addr_t  mem_wr_addr,
  output rdma_hndshk_pkg::wqe_t   mem_wr_data,
  output logic                    wqe_done
);

  logic                   busy;
  rdma_hndshk_pkg::word_t wqe_idx;
  rdma_hndshk_pkg::word_t wrid;
  logic                   last_wqe;

  // Batch fields, captured when the batch starts.
  rdma_hndshk_pkg::word_t count_q;
  rdma_hndshk_pkg::qpid_t qpid_q;
  rdma_hndshk_pkg::word_t len_q;
  rdma_hndshk_pkg::word_t opcode_q;
  rdma_hndshk_pkg::word_t r_key_q;
  rdma_hndshk_pkg::addr_t cur_addr;
  rdma_hndshk_pkg::addr_t cur_laddr;

  assign last_wqe = busy && (wqe_idx == count_q - 32'd1);

  always_ff @(posedge axis_aclk) begin
    if (!axis_rstn) begin
      busy    <= 1'b0;
      wqe_idx <= '0;
      wrid    <= '0;
    end else if (wqe_start && (wqe_count != '0)) begin
      busy    <= 1'b1;
      wqe_idx <= '0;
    end else if (busy) begin
      // The request ID runs on across batches.
      wrid <= wrid + 32'd1;
      if (last_wqe) begin
        busy <= 1'b0;
      end else begin
        wqe_idx <= wqe_idx + 32'd1;
      end
    end
  end

  // Running addresses replace the index multiplies.
  always_ff @(posedge axis_aclk) begin
    if (wqe_start) begin
      count_q   <= wqe_count;
      qpid_q    <= qpid;
      len_q     <= payload_len;
      opcode_q  <= opcode;
      r_key_q   <= r_key;
      cur_addr  <= sq_addr;
      cur_laddr <= laddr;
    end else if (busy) begin
      cur_addr  <= cur_addr + 64'(rdma_hndshk_pkg::WQE_BYTES);
      cur_laddr <= cur_laddr + 64'(len_q);
    end
  end

  assign mem_wr_valid = busy;
  assign mem_wr_addr  = cur_addr;
  assign mem_wr_data  = {48'd0, qpid_q, cur_laddr, r_key_q, len_q, opcode_q, wrid};

  // An empty batch finishes in the start cycle.
  assign wqe_done = last_wqe || (wqe_start && (wqe_count == '0));

endmodule

// File: src/cmd_regs.sv
// Command register file.
// Host write strobes load the work-request fields; a write to the go
// register raises a one-cycle go pulse on the following cycle.
`timescale 1ns/1ps

module cmd_regs (
  input  logic                      axis_aclk,
  input  logic                      axis_rstn,
  input  logic                      cfg_valid,
  input  rdma_hndshk_pkg::cfg_idx_t cfg_idx,
  input  rdma_hndshk_pkg::word_t    cfg_data,
  output rdma_hndshk_pkg::qpid_t    qpid,
  output rdma_hndshk_pkg::word_t    wqe_count,
  output rdma_hndshk_pkg::addr_t    laddr,
  output rdma_hndshk_pkg::word_t    payload_len,
  output rdma_hndshk_pkg::word_t    opcode,
  output rdma_hndshk_pkg::word_t    r_key,
  output rdma_hndshk_pkg::addr_t    sq_addr,
  output rdma_hndshk_pkg::word_t    sq_pidb_addr,
  output logic                      go
);

  always_ff @(posedge axis_aclk) begin
    if (!axis_rstn) begin
      qpid         <= '0;
      wqe_count    <= '0;
      laddr        <= '0;
      payload_len  <= '0;
      opcode       <= '0;
      r_key        <= '0;
      sq_addr      <= '0;
      sq_pidb_addr <= '0;
      go           <= 1'b0;
    end else begin
      go <= cfg_valid && (cfg_idx == rdma_hndshk_pkg::REG_GO);
      if (cfg_valid) begin
        // The 64-bit addresses are loaded one half at a time.
        case (cfg_idx)
          rdma_hndshk_pkg::REG_QPID:         qpid          <= cfg_data[15:0];
          rdma_hndshk_pkg::REG_WQE_COUNT:    wqe_count     <= cfg_data;
          rdma_hndshk_pkg::REG_LADDR_LSB:    laddr[31:0]   <= cfg_data;
          rdma_hndshk_pkg::REG_LADDR_MSB:    laddr[63:32]  <= cfg_data;
          rdma_hndshk_pkg::REG_PAYLOAD_LEN:  payload_len   <= cfg_data;
          rdma_hndshk_pkg::REG_OPCODE:       opcode        <= cfg_data;
          rdma_hndshk_pkg::REG_R_KEY:        r_key         <= cfg_data;
          rdma_hndshk_pkg::REG_SQ_ADDR_LSB:  sq_addr[31:0] <= cfg_data;
          rdma_hndshk_pkg::REG_SQ_ADDR_MSB:  sq_addr[63:32] <= cfg_data;
          rdma_hndshk_pkg::REG_SQ_PIDB_ADDR: sq_pidb_addr  <= cfg_data;
          default: ;
        endcase
      end
    end
  end

endmodule

// File: src/rdma_hndshk_pkg.sv
// RDMA send-queue handshake engine, shared definitions.
// Widths, the command register map, vector types and the sequencer
// state encoding used across the engine.

package rdma_hndshk_pkg;

  // ****************************************
  // Vector types
  // ****************************************

  typedef logic [31:0]  word_t;
  typedef logic [63:0]  addr_t;
  typedef logic [15:0]  qpid_t;
  typedef logic [31:0]  pidx_t;
  typedef logic [63:0]  timer_t;
  typedef logic [3:0]   cfg_idx_t;

  // Work-queue entry, from bit 0 upward: wrid, opcode, payload length,
  // remote key, local address, zero-extended queue-pair ID.
  typedef logic [255:0] wqe_t;

  // Queue-pair ID low byte on top, low 24 bits of the latency below.
  typedef logic [31:0]  status_t;

  // ****************************************
  // Constants
  // ****************************************

  localparam int unsigned WQE_BYTES    = 64;
  localparam int unsigned LATENCY_BITS = 24;

  // Command register map.
  localparam cfg_idx_t REG_QPID         = 4'd0;
  localparam cfg_idx_t REG_WQE_COUNT    = 4'd1;
  localparam cfg_idx_t REG_LADDR_LSB    = 4'd2;
  localparam cfg_idx_t REG_LADDR_MSB    = 4'd3;
  localparam cfg_idx_t REG_PAYLOAD_LEN  = 4'd4;
  localparam cfg_idx_t REG_OPCODE       = 4'd5;
  localparam cfg_idx_t REG_R_KEY        = 4'd6;
  localparam cfg_idx_t REG_SQ_ADDR_LSB  = 4'd7;
  localparam cfg_idx_t REG_SQ_ADDR_MSB  = 4'd8;
  localparam cfg_idx_t REG_SQ_PIDB_ADDR = 4'd9;
  localparam cfg_idx_t REG_GO           = 4'd15;

  // ****************************************
  // Sequencer states
  // ****************************************

  typedef enum logic [2:0] {
    IDLE,
    WRITE_WQE,
    RING_SQDB,
    WAIT_CQDB,
    REPORT
  } seq_state_t;

endpackage
